//--- Bender.yml
package:
  name: instruction_fetch

export_include_dirs:
  - hw

sources:
  - hw/fetch_pkg.sv
  - hw/icache.sv
  - hw/burst_rom.sv
  - hw/fetch_perf.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/fetch_checker.sv
      - bench/fetch_tb.sv

//--- bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock; // 8 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    #1;
    reset = 1'b0;
  end

endmodule

//--- bench/fetch_cases.txt
// columns op_exp_addr: op 0 fetch, 1 fence, 2 count check, f end of list
// exp is the first-cycle hit of a fetch, or the total refills for a count check
0_00_00000104 // cold miss, line 8
0_01_00000100
0_01_00000108
0_01_0000010c
0_01_00000110
0_01_00000114
0_01_00000118
0_01_0000011c
0_01_00000000 // filled while memory loads
0_00_00000a1c // same set as 0, new tag
0_00_00000000
0_00_00000a00
0_00_00001100 // aliases 0x100 in memory
0_00_00000100
0_00_000007f8 // burst wraps from word 6
0_01_000007e0
0_01_000007ec
1_00_00000000
0_00_00000108
0_01_000007f0
0_00_00000a00
2_0b_00000000
f_00_00000000

//--- bench/fetch_checker.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_checker
  import fetch_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  addr_t                      fetch_addr,
  input  logic                       hit,
  input  word_t                      inst,
  input  logic                       load_en,
  input  logic [`ROM_DEPTH_LOG2-1:0] load_row,
  input  beat_t                      load_data,
  input  count_t                     refill_count,
  input  count_t                     busy_count,
  input  int                         op_id,
  input  logic [3:0]                 op_kind,
  input  logic [7:0]                 op_exp,
  output int                         test_count,
  output int                         error_count
);

  localparam int SETS = 1 << `FETCH_INDEX_W;
  localparam int TAG_W = 32 - `FETCH_OFFSET_W - `FETCH_INDEX_W;

  beat_t shadow_mem [1 << `ROM_DEPTH_LOG2];
  logic [SETS-1:0] model_valid;
  logic [TAG_W-1:0] model_tag [SETS];
  int misses; // refills the tag model expects
  int last_id;
  int err_at_start;
  logic prev_reset;
  logic fetch_pending;
  logic fence_pending;
  logic exp_hit;
  word_t exp_word;
  addr_t cur_addr;

  always @(posedge clock) begin
    if (load_en) begin
      shadow_mem[load_row] <= load_data;
    end
  end

  function automatic logic model_hit(input addr_t a);
    set_index_t idx;
    idx = a[`FETCH_OFFSET_W +: `FETCH_INDEX_W];
    return model_valid[idx] && (model_tag[idx] == a[31 -: TAG_W]);
  endfunction

  task automatic model_fill(input addr_t a);
    set_index_t idx;
    idx = a[`FETCH_OFFSET_W +: `FETCH_INDEX_W];
    model_valid[idx] = 1'b1;
    model_tag[idx] = a[31 -: TAG_W];
    misses++;
  endtask

  // memory wraps at 4 KiB, bit 2 picks the lane
  function automatic word_t shadow_word(input addr_t a);
    beat_t row;
    row = shadow_mem[a[3 +: `ROM_DEPTH_LOG2]];
    return a[2] ? row[63:32] : row[31:0];
  endfunction

  task automatic expect_equal(input string name, input logic [63:0] got,
                              input logic [63:0] want);
    if (got !== want) begin
      $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, want);
      error_count++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("at %0t: %s", $time, what);
    error_count++;
  endtask

  task automatic close_test(input string what);
    test_count++;
    $display("test %0d %s: %s", test_count, what,
             (error_count == err_at_start) ? "ok" : "failed");
  endtask

  always @(negedge clock) begin
    if (reset) begin
      prev_reset = 1'b1;
      model_valid = '0;
      misses = 0;
      test_count = 0;
      error_count = 0;
      fetch_pending = 1'b0;
      fence_pending = 1'b0;
      last_id = op_id;
    end else begin
      if (prev_reset) begin
        prev_reset = 1'b0;
        err_at_start = error_count;
        expect_equal("hit", hit, 0);
        expect_equal("refill_count", refill_count, 0);
        expect_equal("busy_count", busy_count, 0);
        model_fill(fetch_addr); // held address refills right away
        close_test("after reset");
      end
      if (fence_pending) begin
        fence_pending = 1'b0;
        if (hit !== 1'b0) begin
          report_failure("the held line still hits after the fence");
        end
        close_test($sformatf("fence with %h held", cur_addr));
      end
      if (op_id != last_id) begin
        last_id = op_id;
        err_at_start = error_count;
        cur_addr = fetch_addr;
        case (op_kind)
          4'h0: begin
            exp_hit = model_hit(fetch_addr);
            if (op_exp[0] !== exp_hit) begin
              report_failure($sformatf("case file and tag model disagree on %h", fetch_addr));
            end
            expect_equal("hit", hit, exp_hit);
            if (!exp_hit) begin
              model_fill(fetch_addr);
            end
            exp_word = shadow_word(fetch_addr);
            fetch_pending = 1'b1;
          end
          4'h1: begin
            model_valid = '0;
            model_fill(fetch_addr);
            fence_pending = 1'b1;
          end
          4'h2: begin
            if (op_exp != misses[7:0]) begin
              report_failure($sformatf("case file expects %0d refills, tag model has %0d",
                                       op_exp, misses));
            end
            expect_equal("refill_count", refill_count, misses);
            expect_equal("busy_count", busy_count, misses * (9 + `ROM_LATENCY));
            close_test($sformatf("counts after %0d refills", misses));
          end
          default: report_failure($sformatf("unknown operation %h", op_kind));
        endcase
      end
      if (fetch_pending && hit === 1'b1) begin
        fetch_pending = 1'b0;
        expect_equal("inst", inst, exp_word);
        close_test($sformatf("fetch %h %s", cur_addr, exp_hit ? "hit" : "miss"));
      end
    end
  end

endmodule

//--- bench/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_tb
  import fetch_pkg::*;
();

  localparam int ROWS = 1 << `ROM_DEPTH_LOG2;
  localparam int MAX_CASES = 64;

  logic clock;
  logic reset;
  addr_t fetch_addr;
  logic fence;
  logic hit;
  word_t inst;
  logic load_en;
  logic [`ROM_DEPTH_LOG2-1:0] load_row;
  beat_t load_data;
  count_t refill_count;
  count_t busy_count;
  int op_id;
  logic [3:0] op_kind;
  logic [7:0] op_exp;
  int test_count;
  int error_count;
  int tb_errors;
  logic [43:0] cases [MAX_CASES]; // op, expected value, address
  logic [31:0] seed;
  int n_ops;
  int cycle_count = 0;
  int cycle_limit = 1000;

  clock_gen u_clock_gen (.clock(clock), .reset(reset));

  fetch_top UUT (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .fence        (fence),
    .hit          (hit),
    .inst         (inst),
    .load_en      (load_en),
    .load_row     (load_row),
    .load_data    (load_data),
    .refill_count (refill_count),
    .busy_count   (busy_count)
  );

  fetch_checker u_checker (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .hit          (hit),
    .inst         (inst),
    .load_en      (load_en),
    .load_row     (load_row),
    .load_data    (load_data),
    .refill_count (refill_count),
    .busy_count   (busy_count),
    .op_id        (op_id),
    .op_kind      (op_kind),
    .op_exp       (op_exp),
    .test_count   (test_count),
    .error_count  (error_count)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // runs during reset too, rows of line 0 are in place before the first refill
  task automatic load_memory();
    for (int i = 0; i < ROWS; i++) begin
      seed = xorshift32(seed);
      load_data[63:32] = seed;
      seed = xorshift32(seed);
      load_data[31:0] = seed;
      load_row = `ROM_DEPTH_LOG2'(i);
      load_en = 1'b1;
      @(posedge clock);
      #1;
    end
    load_en = 1'b0;
  endtask

  task automatic wait_hit_and_hold();
    @(negedge clock);
    while (hit !== 1'b1) begin
      @(negedge clock);
    end
    @(posedge clock); // hit cycle ends
    @(posedge clock); // one more cycle held
    #1;
  endtask

  task automatic run_fetch(input addr_t addr, input logic [7:0] exp);
    fetch_addr = addr;
    op_kind = 4'h0;
    op_exp = exp;
    op_id++;
    wait_hit_and_hold();
  endtask

  task automatic run_fence();
    fence = 1'b1;
    op_kind = 4'h1;
    op_exp = '0;
    op_id++;
    @(posedge clock);
    #1;
    fence = 1'b0;
    wait_hit_and_hold(); // held line refills
  endtask

  task automatic run_count(input logic [7:0] exp);
    op_kind = 4'h2;
    op_exp = exp;
    op_id++;
    @(posedge clock);
    #1;
  endtask

  initial begin
    fetch_addr = '0;
    fence = 1'b0;
    load_en = 1'b0;
    load_row = '0;
    load_data = '0;
    op_id = 0;
    op_kind = '0;
    op_exp = '0;
    tb_errors = 0;
    seed = 32'hae5dc08d;
    $readmemh("bench/fetch_cases.txt", cases);
    n_ops = 0;
    while (n_ops < MAX_CASES && cases[n_ops][43:40] !== 4'hf && ^cases[n_ops] !== 1'bx) begin
      n_ops++;
    end
    // a fetch or fence takes at most 12 + latency cycles
    cycle_limit = 8 + ROWS + n_ops * (12 + `ROM_LATENCY) + 50;
    @(posedge clock);
    #1;
    load_memory();
    for (int i = 0; i < n_ops; i++) begin
      case (cases[i][43:40])
        4'h0: run_fetch(cases[i][31:0], cases[i][39:32]);
        4'h1: run_fence();
        4'h2: run_count(cases[i][39:32]);
        default: begin
          $display("case line %0d holds an unknown operation", i);
          tb_errors++;
        end
      endcase
    end
    if (n_ops == 0) begin
      $display("no cases could be read from bench/fetch_cases.txt");
      tb_errors++;
    end
    $display("%0d tests run, %0d failures", test_count, error_count + tb_errors);
    if (error_count == 0 && tb_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

//--- hw/burst_rom.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module burst_rom
  import fetch_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       load_en,
  input  logic [`ROM_DEPTH_LOG2-1:0] load_row,
  input  beat_t                      load_data,
  input  logic                       ar_valid,
  input  rd_req_t                    ar_req,
  output logic                       ar_ready,
  output logic                       r_valid,
  output rd_beat_t                   r_beat,
  input  logic                       r_ready
);

  localparam int ROWS = 1 << `ROM_DEPTH_LOG2;
  localparam int LINE_WORDS = 1 << (`FETCH_OFFSET_W - 2);
  localparam int WAIT_W = $clog2(`ROM_LATENCY + 1);

  beat_t mem [ROWS];

  logic active; // a burst has been accepted
  logic [WAIT_W-1:0] wait_cnt;
  addr_t word_addr; // word of the current beat
  addr_t next_addr;
  logic [7:0] beats_left;
  logic wrap;
  logic ar_fire;
  logic r_fire;

  always_ff @(posedge clock) begin
    if (load_en) begin
      mem[load_row] <= load_data;
    end
  end

  assign ar_ready = ~active;
  assign ar_fire = ar_valid & ar_ready;
  assign r_valid = active & (wait_cnt == '0);
  assign r_fire = r_valid & r_ready;

  // whole row goes out and the cache picks the lane
  assign r_beat.data = mem[word_addr[3 +: `ROM_DEPTH_LOG2]];
  assign r_beat.last = (beats_left == 8'd0);

  always_comb begin
    next_addr = word_addr + 32'd4;
    if (wrap) begin
      next_addr[31:`FETCH_OFFSET_W] = word_addr[31:`FETCH_OFFSET_W]; // stay in the line
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      active <= 1'b0;
      wait_cnt <= '0;
    end else if (ar_fire) begin
      active <= 1'b1;
      wait_cnt <= WAIT_W'(`ROM_LATENCY - 1);
    end else if (active) begin
      if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 1'b1;
      end else if (r_fire && r_beat.last) begin
        active <= 1'b0;
      end
    end
  end

  // burst address and length held under back-pressure
  always_ff @(posedge clock) begin
    if (ar_fire) begin
      word_addr <= {ar_req.addr[31:2], 2'b00};
      beats_left <= ar_req.len;
      wrap <= ar_req.wrap;
    end else if (r_fire) begin
      word_addr <= next_addr;
      beats_left <= beats_left - 1'b1;
    end
  end

  // the wrap above only covers one line
  wrap_len: assert property (@(posedge clock) disable iff (reset)
    ar_fire && ar_req.wrap |-> ar_req.len == 8'(LINE_WORDS - 1));

  beat_held: assert property (@(posedge clock) disable iff (reset)
    r_valid && !r_ready |=> r_valid && $stable(r_beat));

endmodule

//--- hw/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// line geometry
`define FETCH_OFFSET_W 5 // 32-byte lines
`define FETCH_INDEX_W 4  // 16 sets

// backing store
`define ROM_DEPTH_LOG2 9 // 64-bit rows, 4 KiB
`define ROM_LATENCY 2    // accept to first beat

`endif

//--- hw/fetch_perf.sv
`timescale 1ns/1ps

module fetch_perf
  import fetch_pkg::*;
(
  input  logic   clock,
  input  logic   reset,
  input  logic   busy,
  input  logic   ar_fire,
  output count_t refill_count,
  output count_t busy_count
);

  // stops at all ones instead of rolling over
  function automatic count_t sat_inc(input count_t value, input logic en);
    count_t result;
    result = value;
    if (en && value != '1) begin
      result = value + 1'b1;
    end
    return result;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      refill_count <= '0;
      busy_count <= '0;
    end else begin
      refill_count <= sat_inc(refill_count, ar_fire); // one per burst
      busy_count <= sat_inc(busy_count, busy);
    end
  end

endmodule

//--- hw/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [63:0] beat_t;
  typedef logic [`FETCH_INDEX_W-1:0] set_index_t;
  typedef logic [`FETCH_OFFSET_W-3:0] word_off_t; // word within a line
  typedef logic [31:0] count_t;

  typedef struct packed {
    addr_t addr;     // first word of the burst
    logic [7:0] len; // beats minus one
    logic wrap;
  } rd_req_t;

  typedef struct packed {
    beat_t data;
    logic last;
  } rd_beat_t;

  // one-hot refill states
  typedef enum logic [2:0] {
    st_idle     = 3'b001,
    st_request  = 3'b010,
    st_response = 3'b100
  } refill_state_t;

endpackage

//--- hw/fetch_top.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_top
  import fetch_pkg::*;
(
  input  logic                       clock,
  input  logic                       reset,
  input  addr_t                      fetch_addr,
  input  logic                       fence,
  output logic                       hit,
  output word_t                      inst,
  input  logic                       load_en,
  input  logic [`ROM_DEPTH_LOG2-1:0] load_row,
  input  beat_t                      load_data,
  output count_t                     refill_count,
  output count_t                     busy_count
);

  logic ar_valid;
  logic ar_ready;
  rd_req_t ar_req;
  logic r_valid;
  logic r_ready;
  rd_beat_t r_beat;
  logic busy;
  logic ar_fire;

  assign ar_fire = ar_valid & ar_ready; // address handshake

  icache u_icache (
    .clock    (clock),
    .reset    (reset),
    .fence    (fence),
    .addr     (fetch_addr),
    .hit      (hit),
    .inst     (inst),
    .busy     (busy),
    .ar_valid (ar_valid),
    .ar_req   (ar_req),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r_beat   (r_beat),
    .r_ready  (r_ready)
  );

  burst_rom u_burst_rom (
    .clock     (clock),
    .reset     (reset),
    .load_en   (load_en),
    .load_row  (load_row),
    .load_data (load_data),
    .ar_valid  (ar_valid),
    .ar_req    (ar_req),
    .ar_ready  (ar_ready),
    .r_valid   (r_valid),
    .r_beat    (r_beat),
    .r_ready   (r_ready)
  );

  fetch_perf u_fetch_perf (
    .clock        (clock),
    .reset        (reset),
    .busy         (busy),
    .ar_fire      (ar_fire),
    .refill_count (refill_count),
    .busy_count   (busy_count)
  );

endmodule

//--- hw/icache.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module icache
  import fetch_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     fence,
  input  addr_t    addr,
  output logic     hit,
  output word_t    inst,
  output logic     busy,
  output logic     ar_valid,
  output rd_req_t  ar_req,
  input  logic     ar_ready,
  input  logic     r_valid,
  input  rd_beat_t r_beat,
  output logic     r_ready
);

  localparam int SETS = 1 << `FETCH_INDEX_W;
  localparam int LINE_WORDS = 1 << (`FETCH_OFFSET_W - 2);
  localparam int TAG_W = 32 - `FETCH_OFFSET_W - `FETCH_INDEX_W;

  logic [SETS-1:0] line_valid;
  logic [TAG_W-1:0] line_tag [SETS];
  word_t line_data [SETS][LINE_WORDS];

  logic [TAG_W-1:0] tag;
  set_index_t index;
  word_off_t off;

  refill_state_t state;
  refill_state_t state_next;
  word_off_t refill_off; // word the next beat belongs to
  logic ar_fire;
  logic r_fire;
  logic fill_done;

  assign tag = addr[31 -: TAG_W];
  assign index = addr[`FETCH_OFFSET_W +: `FETCH_INDEX_W];
  assign off = addr[2 +: `FETCH_OFFSET_W - 2];

  // lookup, same cycle
  assign hit = line_valid[index] & (line_tag[index] == tag);
  assign inst = line_data[index][off];
  assign busy = (state != st_idle) | ~hit; // the miss cycle in idle counts too

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      st_idle: begin
        if (~hit) begin
          state_next = st_request;
        end
      end
      st_request: begin
        if (ar_ready) begin
          state_next = st_response;
        end
      end
      st_response: begin
        if (fill_done) begin
          state_next = st_idle;
        end
      end
      default: begin
        state_next = st_idle;
      end
    endcase
  end

  // critical word first, wrapping around the line
  assign ar_valid = (state == st_request);
  assign ar_req = '{addr: {addr[31:2], 2'b00}, len: 8'(LINE_WORDS - 1), wrap: 1'b1};
  assign r_ready = (state == st_response);

  assign ar_fire = ar_valid & ar_ready;
  assign r_fire = r_valid & r_ready;
  assign fill_done = r_fire & r_beat.last;

  always_ff @(posedge clock) begin
    if (reset) begin
      refill_off <= '0;
    end else if (ar_fire) begin
      refill_off <= off;
    end else if (r_fire) begin
      refill_off <= refill_off + 1'b1; // wraps with the burst
    end
  end

  always_ff @(posedge clock) begin
    if (r_fire) begin
      // lane follows bit 2 of the word address
      line_data[index][refill_off] <= refill_off[0] ? r_beat.data[63:32]
                                                    : r_beat.data[31:0];
    end
    if (fill_done) begin
      line_tag[index] <= tag;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      line_valid <= '0;
    end else begin
      if (fence) begin
        line_valid <= '0;
      end
      if (ar_fire) begin
        line_valid[index] <= 1'b0; // old line gets overwritten
      end
      if (fill_done) begin
        line_valid[index] <= 1'b1; // wins over a fence in the same cycle
      end
    end
  end

  ar_held: assert property (@(posedge clock) disable iff (reset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_req));

  r_in_response: assert property (@(posedge clock) disable iff (reset)
    r_valid |-> state == st_response);

  // the refill writes into the set of the current address
  addr_held: assert property (@(posedge clock) disable iff (reset)
    busy && !fill_done |=> $stable(addr));

endmodule

//--- vlog.f
+incdir+hw
hw/fetch_pkg.sv
hw/icache.sv
hw/burst_rom.sv
hw/fetch_perf.sv
hw/fetch_top.sv
bench/clock_gen.sv
bench/fetch_checker.sv
bench/fetch_tb.sv
